// File: bench/lsu_properties.sv
// lsu_properties: concurrent checks on reset state, load data after stores and dropped stores
`timescale 1ns/1ps

module lsu_properties (
  input logic             i_clk,
  input logic             i_reset,
  input lsu_pkg::addr_t   i_lsu_addr,
  input logic             i_lsu_wren,
  input lsu_pkg::access_t i_access,
  input lsu_pkg::word_t   o_ld_data,
  input lsu_pkg::io_out_t o_io
);
  import lsu_pkg::*;

  logic is_store;
  logic out_bank_hit;  // one of the five output registers
  logic store_dropped; // switches or unmapped

  assign is_store      = i_lsu_wren && (i_access <= ACC_SW);
  assign out_bank_hit  = (i_lsu_addr[31:16] == IO_BASE) && (i_lsu_addr[IO_SEL_LSB +: 4] < 4'd5);
  assign store_dropped = is_store && (i_lsu_addr >= addr_t'(MEM_BYTES)) && !out_bank_hit;

  a_io_reset_clear: assert property (@(posedge i_clk) i_reset |=> (o_io == '0))
    else $error("peripheral outputs not cleared after reset");

  a_ld_zero_after_store: assert property (
    @(posedge i_clk) disable iff (i_reset) is_store |=> (o_ld_data == '0)
  ) else $error("load data not zero in the cycle after a store");

  // nothing writable behind the switches or a hole
  a_io_hold_on_drop: assert property (
    @(posedge i_clk) disable iff (i_reset) store_dropped |=> $stable(o_io)
  ) else $error("store to switches or unmapped space changed the peripheral outputs");

endmodule

bind lsu_top lsu_properties u_props (
  .i_clk      (i_clk),
  .i_reset    (i_reset),
  .i_lsu_addr (i_lsu_addr),
  .i_lsu_wren (i_lsu_wren),
  .i_access   (i_access),
  .o_ld_data  (o_ld_data),
  .o_io       (o_io)
);

// File: bench/lsu_tb.sv
// lsu_tb: table-driven testbench for lsu_top with a reference model of memory and peripherals
`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  // one table row, stimulus plus expected response
  typedef struct packed {
    addr_t   addr;
    word_t   wdata;
    access_t access;
    logic    wren;
    word_t   sw;
    word_t   exp_ld;
    io_out_t exp_io;
  } vec_t;

  logic    i_clk = 1'b0;
  logic    i_reset;
  addr_t   i_lsu_addr;
  word_t   i_st_data;
  logic    i_lsu_wren;
  access_t i_access;
  word_t   i_io_sw;
  word_t   o_ld_data;
  io_out_t o_io;

  vec_t  vecs[$];
  string names[$];

  word_t model_mem [MEM_WORDS]; // reference memory, not reset
  word_t model_io [NUM_IO_REGS];
  word_t model_sw_q;            // switch value held by the DUT

  int seed = 32'h21d1_4ec3;
  int cycle_count = 0;
  int max_cycles = 0;
  int ld_errors = 0;
  int io_errors = 0;

  lsu_top dut (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_lsu_addr (i_lsu_addr),
    .i_st_data  (i_st_data),
    .i_lsu_wren (i_lsu_wren),
    .i_access   (i_access),
    .i_io_sw    (i_io_sw),
    .o_ld_data  (o_ld_data),
    .o_io       (o_io)
  );

  always #20 i_clk = ~i_clk; // 40 ns period

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  // -1 unmapped, 0 memory, 1..5 output registers, 6 switches
  function automatic int map_index(addr_t a);
    if (a < 32'h0000_0800) return 0;
    if (a[31:16] == 16'h1000 && a[15:12] <= 4'd4) return 1 + int'(a[15:12]);
    if (a[31:16] == 16'h1001 && a[15:12] == 4'd0) return 6;
    return -1;
  endfunction

  function automatic word_t merge_store(word_t old, access_t acc, lane_t lane, word_t data);
    word_t w;
    w = old;
    case (acc)
      ACC_SB: w[8*lane +: 8] = data[7:0];
      ACC_SH: begin
        if (lane[1])
          w[31:16] = data[15:0]; // upper halfword
        else
          w[15:0] = data[15:0];
      end
      default: w = data; // word store ignores the offset
    endcase
    return w;
  endfunction

  function automatic word_t format_load(word_t src, access_t acc, lane_t lane);
    word_t       shifted;
    logic [7:0]  b;
    logic [15:0] h;
    shifted = src >> (8 * lane);
    b = shifted[7:0];
    h = lane[1] ? src[31:16] : src[15:0];
    case (acc)
      ACC_LB:  return {{24{b[7]}}, b};
      ACC_LBU: return {24'h0, b};
      ACC_LH:  return {{16{h[15]}}, h};
      ACC_LHU: return {16'h0, h};
      default: return src;
    endcase
  endfunction

  function automatic io_out_t model_outputs();
    io_out_t o;
    word_t   digit_reg;
    o.ledr = model_io[0];
    o.ledg = model_io[1];
    o.lcd  = model_io[4];
    for (int d = 0; d < 8; d++) begin
      digit_reg = (d < 4) ? model_io[2] : model_io[3];
      o.hex[d]  = digit_reg[8*(d%4) +: 7]; // bit 7 of each byte unused
    end
    return o;
  endfunction

  // runs one row through the model and appends it to the table
  task automatic add_vec(string name, access_t acc, addr_t addr, word_t data, word_t sw);
    vec_t  v;
    int    idx;
    word_t src;
    v.addr   = addr;
    v.wdata  = data;
    v.access = acc;
    v.wren   = (acc <= ACC_SW);
    v.sw     = sw;
    v.exp_ld = '0; // stores read back zero
    idx = map_index(addr);
    if (v.wren) begin
      if (idx == 0)
        model_mem[addr[MEM_AW+1:2]] = merge_store(model_mem[addr[MEM_AW+1:2]], acc, addr[1:0], data);
      else if (idx >= 1 && idx <= 5)
        model_io[idx-1] = merge_store(model_io[idx-1], acc, addr[1:0], data);
    end else begin
      if (idx == 0)
        src = model_mem[addr[MEM_AW+1:2]];
      else if (idx >= 1 && idx <= 5)
        src = model_io[idx-1];
      else if (idx == 6)
        src = model_sw_q; // previous row's switch value
      else
        src = '0;
      v.exp_ld = format_load(src, acc, addr[1:0]);
    end
    model_sw_q = sw;
    v.exp_io   = model_outputs();
    vecs.push_back(v);
    names.push_back(name);
  endtask

  task automatic build_table();
    addr_t a;
    word_t swv;
    addr_t holes [6];
    holes = '{32'h0000_0800, 32'h1000_5000, 32'h1000_f000,
              32'h1001_1000, 32'h1002_0000, 32'hffff_fffc};
    for (int r = 0; r < NUM_IO_REGS; r++) begin
      model_io[r] = '0;
    end
    model_sw_q = '0;
    // word round trip, back to back
    add_vec("sw_w0", ACC_SW, 32'h0000_0000, rand_word(), '0);
    add_vec("sw_w1", ACC_SW, 32'h0000_0004, rand_word(), '0);
    add_vec("sw_last", ACC_SW, 32'h0000_07fc, rand_word(), '0);
    add_vec("lw_w0", ACC_LW, 32'h0000_0000, '0, '0);
    add_vec("lw_w1", ACC_LW, 32'h0000_0004, '0, '0);
    add_vec("lw_last", ACC_LW, 32'h0000_07fc, '0, '0);
    add_vec("sw_off3", ACC_SW, 32'h0000_000b, rand_word(), '0);
    add_vec("lw_off3", ACC_LW, 32'h0000_0008, '0, '0);
    // byte and halfword merges
    add_vec("sw_merge_b", ACC_SW, 32'h0000_0010, rand_word(), '0);
    add_vec("sw_merge_h", ACC_SW, 32'h0000_0014, rand_word(), '0);
    for (int off = 0; off < 4; off++) begin
      a = 32'h0000_0010 + addr_t'(off);
      add_vec($sformatf("sb_off%0d", off), ACC_SB, a, rand_word(), '0);
      add_vec($sformatf("lw_after_sb%0d", off), ACC_LW, 32'h0000_0010, '0, '0);
      a = 32'h0000_0014 + addr_t'(off);
      add_vec($sformatf("sh_off%0d", off), ACC_SH, a, rand_word(), '0);
      add_vec($sformatf("lw_after_sh%0d", off), ACC_LW, 32'h0000_0014, '0, '0);
    end
    // sub-word loads, negative and positive bytes
    add_vec("sw_neg", ACC_SW, 32'h0000_0020, 32'hf3a2_9180, '0);
    add_vec("sw_pos", ACC_SW, 32'h0000_0024, 32'h7f3a_1c05, '0);
    for (int off = 0; off < 4; off++) begin
      a = 32'h0000_0020 + addr_t'(off);
      add_vec($sformatf("lb_neg%0d", off), ACC_LB, a, '0, '0);
      add_vec($sformatf("lbu_neg%0d", off), ACC_LBU, a, '0, '0);
      add_vec($sformatf("lh_neg%0d", off), ACC_LH, a, '0, '0);
      add_vec($sformatf("lhu_neg%0d", off), ACC_LHU, a, '0, '0);
      add_vec($sformatf("lb_pos%0d", off), ACC_LB, a + 32'h4, '0, '0);
    end
    add_vec("lh_pos2", ACC_LH, 32'h0000_0026, '0, '0);
    // peripheral registers, every byte with bit 7 set
    for (int k = 0; k < 5; k++) begin
      a = 32'h1000_0000 | (addr_t'(k) << 12);
      add_vec($sformatf("sw_io%0d", k), ACC_SW, a, rand_word() | 32'h8080_8080, '0);
      add_vec($sformatf("lw_io%0d", k), ACC_LW, a + 32'h10, '0, '0);
    end
    add_vec("sb_ledg_off2", ACC_SB, 32'h1000_1002, rand_word(), '0);
    add_vec("sh_hex74_off2", ACC_SH, 32'h1000_3002, rand_word(), '0);
    add_vec("lw_ledg", ACC_LW, 32'h1000_1000, '0, '0);
    add_vec("lb_hex30_off1", ACC_LB, 32'h1000_2001, '0, '0);
    add_vec("lhu_lcd_off2", ACC_LHU, 32'h1000_4002, '0, '0);
    // switches and unmapped space
    swv = rand_word();
    add_vec("sw_setup", ACC_LW, 32'h2000_0000, '0, swv);
    add_vec("lw_switch", ACC_LW, 32'h1001_0000, '0, swv);
    add_vec("lw_switch_held", ACC_LW, 32'h1001_0004, '0, rand_word());
    add_vec("lhu_switch_off2", ACC_LHU, 32'h1001_0002, '0, '0);
    add_vec("lb_switch_off3", ACC_LB, 32'h1001_0003, '0, '0);
    for (int h = 0; h < 6; h++) begin
      add_vec($sformatf("lw_hole%0d", h), ACC_LW, holes[h], '0, '0);
      add_vec($sformatf("sw_hole%0d", h), ACC_SW, holes[h], rand_word(), '0);
    end
    add_vec("sw_switch", ACC_SW, 32'h1001_0000, rand_word(), '0);
    add_vec("sb_switch", ACC_SB, 32'h1001_0001, rand_word(), '0);
    add_vec("lw_w0_after_drop", ACC_LW, 32'h0000_0000, '0, '0);
    add_vec("lw_last_after_drop", ACC_LW, 32'h0000_07fc, '0, '0);
    add_vec("lw_ledr_after_drop", ACC_LW, 32'h1000_0000, '0, '0);
  endtask

  task automatic drive_row(int r);
    i_lsu_addr <= vecs[r].addr;
    i_st_data  <= vecs[r].wdata;
    i_access   <= vecs[r].access;
    i_lsu_wren <= vecs[r].wren;
    i_io_sw    <= vecs[r].sw;
  endtask

  task automatic drive_idle();
    i_lsu_addr <= 32'h2000_0000; // unmapped load
    i_st_data  <= '0;
    i_access   <= ACC_LW;
    i_lsu_wren <= 1'b0;
    i_io_sw    <= '0;
  endtask

  task automatic check_row(int r);
    assert (o_ld_data === vecs[r].exp_ld) else begin
      ld_errors++;
      $display("FAILED %s: o_ld_data expected %h, actual %h", names[r], vecs[r].exp_ld, o_ld_data);
    end
    assert (o_io === vecs[r].exp_io) else begin
      io_errors++;
      $display("FAILED %s: o_io expected %h, actual %h", names[r], vecs[r].exp_io, o_io);
    end
  endtask

  always @(posedge i_clk) begin
    if (!i_reset) begin
      cycle_count <= cycle_count + 1;
    end
    if (max_cycles > 0 && cycle_count >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    i_reset = 1'b1;
    drive_idle();
    build_table();
    max_cycles = vecs.size() + 20;
    repeat (4) @(posedge i_clk);
    i_reset <= 1'b0;
    @(negedge i_clk);
    assert (o_ld_data === '0) else begin
      ld_errors++;
      $display("FAILED reset: o_ld_data expected %h, actual %h", 32'h0, o_ld_data);
    end
    assert (o_io === '0) else begin
      io_errors++;
      $display("FAILED reset: o_io expected all zero, actual %h", o_io);
    end
    // row r is sampled one edge after it is driven, checked on the following low phase
    for (int r = 0; r <= vecs.size(); r++) begin
      @(posedge i_clk);
      if (r < vecs.size())
        drive_row(r);
      else
        drive_idle();
      @(negedge i_clk);
      if (r > 0)
        check_row(r - 1);
    end
    $display("checks done: %0d load data errors, %0d peripheral output errors",
             ld_errors, io_errors);
    if (ld_errors == 0 && io_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/lsu_pkg.sv
hw/lsu_addr_decode.sv
hw/lsu_store_align.sv
hw/lsu_data_mem.sv
hw/lsu_io_regs.sv
hw/lsu_load_extract.sv
hw/lsu_top.sv
bench/lsu_properties.sv
bench/lsu_tb.sv

// File: hw/lsu_addr_decode.sv
// lsu_addr_decode: address to region decode, write strobes and registered load context
`timescale 1ns/1ps

module lsu_addr_decode (
  input  logic                i_clk,
  input  logic                i_reset,
  input  lsu_pkg::lsu_req_t   i_req,
  output logic                o_mem_we,
  output logic                o_io_we,
  output lsu_pkg::region_t    o_region, // region of the current request
  output lsu_pkg::load_ctrl_t o_ld_ctrl
);
  import lsu_pkg::*;

  logic [3:0] io_sel;
  logic       is_store;
  logic       is_load;
  region_t    region;

  assign io_sel   = i_req.addr[IO_SEL_LSB +: 4];
  assign is_store = i_req.wren && (i_req.access <= ACC_SW);
  assign is_load  = !i_req.wren && (i_req.access >= ACC_LB);

  always_comb begin
    region = REG_NONE;
    if (i_req.addr < addr_t'(MEM_BYTES)) begin
      region = REG_MEM;
    end else if (i_req.addr[31:16] == IO_BASE) begin
      case (io_sel)
        4'd0:    region = REG_LEDR;
        4'd1:    region = REG_LEDG;
        4'd2:    region = REG_HEX30;
        4'd3:    region = REG_HEX74;
        4'd4:    region = REG_LCD;
        default: region = REG_NONE; // reserved slots
      endcase
    end else if (i_req.addr[31:16] == SW_BASE && io_sel == 4'd0) begin
      region = REG_SW;
    end
  end

  assign o_region = region;
  assign o_mem_we = is_store && (region == REG_MEM);
  assign o_io_we  = is_store && (region >= REG_LEDR) && (region <= REG_LCD); // switches read only

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ld_ctrl.region <= REG_NONE;
      o_ld_ctrl.access <= ACC_LW;
      o_ld_ctrl.lane   <= '0;
    end else begin
      o_ld_ctrl.region <= is_load ? region : REG_NONE; // stores read back zero
      o_ld_ctrl.access <= i_req.access;
      o_ld_ctrl.lane   <= i_req.addr[1:0];
    end
  end

endmodule

// File: hw/lsu_data_mem.sv
// lsu_data_mem: byte-writable word memory with registered read
`timescale 1ns/1ps

module lsu_data_mem #(
  parameter int DEPTH_WORDS = lsu_pkg::MEM_WORDS
) (
  input  logic                           i_clk,
  input  logic                           i_we,
  input  logic [$clog2(DEPTH_WORDS)-1:0] i_word_addr,
  input  lsu_pkg::byte_en_t              i_byte_en,
  input  lsu_pkg::word_t                 i_wdata,
  output lsu_pkg::word_t                 o_rdata
);

  logic [31:0] mem [DEPTH_WORDS];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int b = 0; b < 4; b++) begin
        if (i_byte_en[b]) begin
          mem[i_word_addr][8*b +: 8] <= i_wdata[8*b +: 8]; // per-lane write
        end
      end
    end
    o_rdata <= mem[i_word_addr]; // old word on a same-cycle write
  end

endmodule

// File: hw/lsu_io_regs.sv
// lsu_io_regs: output peripheral registers, switch input register and their read port
`timescale 1ns/1ps

module lsu_io_regs (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_we,
  input  lsu_pkg::region_t  i_region,
  input  lsu_pkg::byte_en_t i_byte_en,
  input  lsu_pkg::word_t    i_wdata,
  input  lsu_pkg::word_t    i_io_sw,
  output lsu_pkg::word_t    o_rdata,
  output lsu_pkg::io_out_t  o_io
);
  import lsu_pkg::*;

  word_t      io_q [NUM_IO_REGS]; // ledr, ledg, hex30, hex74, lcd
  word_t      sw_q;
  logic [2:0] io_idx;

  assign io_idx = i_region - REG_LEDR; // only meaningful for output regions

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int r = 0; r < NUM_IO_REGS; r++) begin
        io_q[r] <= '0;
      end
      sw_q <= '0;
    end else begin
      sw_q <= i_io_sw; // sampled every edge
      if (i_we) begin
        for (int b = 0; b < 4; b++) begin
          if (i_byte_en[b]) begin
            io_q[io_idx][8*b +: 8] <= i_wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // read port, one cycle like the memory
  always_ff @(posedge i_clk) begin
    case (i_region)
      REG_LEDR, REG_LEDG, REG_HEX30, REG_HEX74, REG_LCD: o_rdata <= io_q[io_idx];
      REG_SW:  o_rdata <= sw_q;
      default: o_rdata <= '0; // memory and unmapped
    endcase
  end

  always_comb begin
    o_io.ledr = io_q[0];
    o_io.ledg = io_q[1];
    o_io.lcd  = io_q[4];
    // digit k takes bits 6:0 of byte k mod 4
    for (int k = 0; k < 4; k++) begin
      o_io.hex[k]     = io_q[2][8*k +: 7];
      o_io.hex[k + 4] = io_q[3][8*k +: 7];
    end
  end

endmodule

// File: hw/lsu_load_extract.sv
// lsu_load_extract: load source select, lane shift and sign or zero extension
`timescale 1ns/1ps

module lsu_load_extract (
  input  lsu_pkg::load_ctrl_t i_ld_ctrl,
  input  lsu_pkg::word_t      i_mem_rdata,
  input  lsu_pkg::word_t      i_io_rdata,
  output lsu_pkg::word_t      o_ld_data
);
  import lsu_pkg::*;

  word_t       src;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  always_comb begin
    case (i_ld_ctrl.region)
      REG_NONE: src = '0;
      REG_MEM:  src = i_mem_rdata;
      default:  src = i_io_rdata; // any peripheral or switches
    endcase
  end

  // same lane positions as the store side
  assign ld_byte = src[8*i_ld_ctrl.lane +: 8];
  assign ld_half = i_ld_ctrl.lane[1] ? src[31:16] : src[15:0];

  always_comb begin
    case (i_ld_ctrl.access)
      ACC_LB:  o_ld_data = {{24{ld_byte[7]}}, ld_byte};
      ACC_LBU: o_ld_data = {24'd0, ld_byte};
      ACC_LH:  o_ld_data = {{16{ld_half[15]}}, ld_half};
      ACC_LHU: o_ld_data = {16'd0, ld_half};
      default: o_ld_data = src; // LW, and stores already carry REG_NONE
    endcase
  end

endmodule

// File: hw/lsu_pkg.sv
// widths, access and region codes, address map and shared structs for the load/store unit
package lsu_pkg;

  typedef logic [31:0] word_t;    // data word
  typedef logic [31:0] addr_t;    // byte address
  typedef logic [3:0]  byte_en_t; // one bit per byte lane
  typedef logic [1:0]  lane_t;    // byte offset in a word
  typedef logic [2:0]  access_t;  // load/store kind
  typedef logic [2:0]  region_t;  // decoded target
  typedef logic [6:0]  seg7_t;    // one digit, segments g..a

  // access codes, stores first
  localparam access_t ACC_SB  = 3'd0;
  localparam access_t ACC_SH  = 3'd1;
  localparam access_t ACC_SW  = 3'd2;
  localparam access_t ACC_LB  = 3'd3;
  localparam access_t ACC_LH  = 3'd4;
  localparam access_t ACC_LW  = 3'd5;
  localparam access_t ACC_LBU = 3'd6;
  localparam access_t ACC_LHU = 3'd7;

  // region codes; the five output registers are contiguous from REG_LEDR
  localparam region_t REG_NONE  = 3'd0;
  localparam region_t REG_MEM   = 3'd1;
  localparam region_t REG_LEDR  = 3'd2;
  localparam region_t REG_LEDG  = 3'd3;
  localparam region_t REG_HEX30 = 3'd4;
  localparam region_t REG_HEX74 = 3'd5;
  localparam region_t REG_LCD   = 3'd6;
  localparam region_t REG_SW    = 3'd7;

  localparam int MEM_BYTES   = 2048;
  localparam int MEM_WORDS   = MEM_BYTES / 4;
  localparam int MEM_AW      = $clog2(MEM_WORDS); // word index width
  localparam int NUM_IO_REGS = 5;                 // ledr, ledg, hex30, hex74, lcd

  localparam logic [15:0] IO_BASE = 16'h1000; // output bank, addr[31:16]
  localparam logic [15:0] SW_BASE = 16'h1001; // switches, addr[31:16]
  localparam int IO_SEL_LSB = 12;             // 4-bit peripheral index starts here

  // one request, valid for one cycle
  typedef struct packed {
    addr_t   addr;
    word_t   wdata;
    access_t access;
    logic    wren;
  } lsu_req_t;

  // load context carried to the data cycle
  typedef struct packed {
    region_t region;
    access_t access;
    lane_t   lane;
  } load_ctrl_t;

  // peripheral outputs
  typedef struct packed {
    word_t       ledr;
    word_t       ledg;
    seg7_t [0:7] hex; // digit 0 first
    word_t       lcd;
  } io_out_t;

endpackage

// File: hw/lsu_store_align.sv
// lsu_store_align: byte-enable mask and lane placement of store data
`timescale 1ns/1ps

module lsu_store_align (
  input  lsu_pkg::access_t  i_access,
  input  lsu_pkg::lane_t    i_lane,
  input  lsu_pkg::word_t    i_wdata,
  output lsu_pkg::byte_en_t o_byte_en,
  output lsu_pkg::word_t    o_wdata
);
  import lsu_pkg::*;

  always_comb begin
    case (i_access)
      ACC_SB: begin
        o_byte_en = byte_en_t'(4'b0001 << i_lane);
        o_wdata   = {4{i_wdata[7:0]}}; // byte copied to every lane
      end
      ACC_SH: begin
        o_byte_en = i_lane[1] ? 4'b1100 : 4'b0011; // offset bit 0 ignored
        o_wdata   = {2{i_wdata[15:0]}};
      end
      ACC_SW: begin
        o_byte_en = 4'b1111; // whole word regardless of offset
        o_wdata   = i_wdata;
      end
      default: begin
        // loads write nothing
        o_byte_en = 4'b0000;
        o_wdata   = i_wdata;
      end
    endcase
  end

endmodule

// File: hw/lsu_top.sv
// lsu_top: load/store unit with data memory and memory-mapped peripherals
`timescale 1ns/1ps

module lsu_top (
  input  logic             i_clk,
  input  logic             i_reset,
  input  lsu_pkg::addr_t   i_lsu_addr,
  input  lsu_pkg::word_t   i_st_data,
  input  logic             i_lsu_wren,
  input  lsu_pkg::access_t i_access,
  input  lsu_pkg::word_t   i_io_sw,
  output lsu_pkg::word_t   o_ld_data,
  output lsu_pkg::io_out_t o_io
);
  import lsu_pkg::*;

  lsu_req_t   req;
  logic       mem_we;
  logic       io_we;
  region_t    region;
  load_ctrl_t ld_ctrl;
  byte_en_t   byte_en;
  word_t      st_wdata;  // lane-placed store data
  word_t      mem_rdata;
  word_t      io_rdata;

  assign req = '{addr: i_lsu_addr, wdata: i_st_data, access: i_access, wren: i_lsu_wren};

  lsu_addr_decode u_decode (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_req     (req),
    .o_mem_we  (mem_we),
    .o_io_we   (io_we),
    .o_region  (region),
    .o_ld_ctrl (ld_ctrl)
  );

  lsu_store_align u_align (
    .i_access  (req.access),
    .i_lane    (req.addr[1:0]),
    .i_wdata   (req.wdata),
    .o_byte_en (byte_en),
    .o_wdata   (st_wdata)
  );

  lsu_data_mem #(.DEPTH_WORDS(MEM_WORDS)) u_mem (
    .i_clk       (i_clk),
    .i_we        (mem_we),
    .i_word_addr (req.addr[MEM_AW+1:2]),
    .i_byte_en   (byte_en),
    .i_wdata     (st_wdata),
    .o_rdata     (mem_rdata)
  );

  lsu_io_regs u_io (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_we      (io_we),
    .i_region  (region),
    .i_byte_en (byte_en),
    .i_wdata   (st_wdata),
    .i_io_sw   (i_io_sw),
    .o_rdata   (io_rdata),
    .o_io      (o_io)
  );

  lsu_load_extract u_extract (
    .i_ld_ctrl   (ld_ctrl),
    .i_mem_rdata (mem_rdata),
    .i_io_rdata  (io_rdata),
    .o_ld_data   (o_ld_data)
  );

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module lsu_tb -f flist.f -o lsu_sim \
  && ./obj_dir/lsu_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
! grep -q ">>> FAIL" sim.log && grep -q ">>> PASS" sim.log \
  && echo "run.sh: simulation passed" && exit 0
echo "run.sh: simulation failed"
exit 1
